//--- hw/gobou_pkg.sv
package gobou_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // data width of x, w, accumulator and y
  localparam int DWIDTH = 16;
  // full product width
  localparam int PWIDTH = 2 * DWIDTH;
  // rounding shift width
  localparam int LWIDTH = 5;
  localparam int CMD_WIDTH = 34;
  // extra control stages between decode and accumulator write
  localparam int MAC_DELAY = 3;
  // filler bits in the configuration view
  localparam int CFG_PAD = CMD_WIDTH - 2 - 1 - LWIDTH;

  //////////////////////////////////////////////////////////////////////
  // command word
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CFG   = 2'd0,
    CLEAR = 2'd1,
    MAC   = 2'd2,
    EMIT  = 2'd3
  } gobou_op_e;

  // configuration view
  typedef struct packed {
    gobou_op_e          op;
    logic [CFG_PAD-1:0] unused;
    logic               relu_en;
    logic [LWIDTH-1:0]  qbits;
  } gobou_cfg_t;

  // operand view
  typedef struct packed {
    gobou_op_e                op;
    logic signed [DWIDTH-1:0] x;
    logic signed [DWIDTH-1:0] w;
  } gobou_opnd_t;

  // op sits in the top two bits of both views
  typedef union packed {
    gobou_cfg_t  cfg;
    gobou_opnd_t opnd;
  } gobou_cmd_u;

endpackage

//--- hw/gobou_mac_if.sv
`timescale 1ns/1ps

interface gobou_mac_if
  import gobou_pkg::*;
();

  // control, already aligned with the rounded product
  logic accum_we;
  logic clear;
  logic out_en;
  logic relu_en;

  // configuration and operands, straight from the decode registers
  logic        [LWIDTH-1:0] qbits;
  logic signed [DWIDTH-1:0] x;
  logic signed [DWIDTH-1:0] w;

  modport ctrl (
    output accum_we, clear, out_en, relu_en, qbits, x, w
  );

  modport exec (
    input accum_we, clear, out_en, qbits, x, w
  );

  modport res (
    input out_en, relu_en
  );

endinterface

//--- hw/gobou_decode.sv
`timescale 1ns/1ps

module gobou_decode
  import gobou_pkg::*;
(
  input  logic       clk,
  input  logic       xrst,
  input  logic       cmd_valid,
  input  gobou_cmd_u cmd,
  gobou_mac_if.ctrl  mac
);

  gobou_op_e op;
  logic      is_cfg;
  logic      is_clear;
  logic      is_mac;
  logic      is_emit;

  logic        [LWIDTH-1:0] qbits_q;
  logic                     relu_q;
  logic signed [DWIDTH-1:0] x_q;
  logic signed [DWIDTH-1:0] w_q;

  // bit 0 is the decode register, bit MAC_DELAY meets the rounded product
  logic [MAC_DELAY:0] we_pipe;
  logic [MAC_DELAY:0] clear_pipe;
  logic [MAC_DELAY:0] out_pipe;
  logic [MAC_DELAY:0] relu_pipe;

  //////////////////////////////////////////////////////////////////////
  // op decode
  //////////////////////////////////////////////////////////////////////

  // op is in the same place in both views
  assign op       = cmd.cfg.op;
  assign is_cfg   = cmd_valid && (op == CFG);
  assign is_clear = cmd_valid && (op == CLEAR);
  assign is_mac   = cmd_valid && (op == MAC);
  assign is_emit  = cmd_valid && (op == EMIT);

  // configuration, held until the next CFG
  always_ff @(posedge clk) begin
    if (!xrst) begin
      qbits_q <= '0;
      relu_q  <= 1'b0;
    end else if (is_cfg) begin
      qbits_q <= cmd.cfg.qbits;
      relu_q  <= cmd.cfg.relu_en;
    end
  end

  // operands
  always_ff @(posedge clk) begin
    if (is_mac) begin
      x_q <= cmd.opnd.x;
      w_q <= cmd.opnd.w;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control alignment
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!xrst) begin
      we_pipe    <= '0;
      clear_pipe <= '0;
      out_pipe   <= '0;
      relu_pipe  <= '0;
    end else begin
      we_pipe    <= {we_pipe[MAC_DELAY-1:0], is_mac};
      clear_pipe <= {clear_pipe[MAC_DELAY-1:0], is_clear};
      out_pipe   <= {out_pipe[MAC_DELAY-1:0], is_emit};
      // relu setting in force when the command was issued
      relu_pipe  <= {relu_pipe[MAC_DELAY-1:0], relu_q};
    end
  end

  assign mac.accum_we = we_pipe[MAC_DELAY];
  assign mac.clear    = clear_pipe[MAC_DELAY];
  assign mac.out_en   = out_pipe[MAC_DELAY];
  assign mac.relu_en  = relu_pipe[MAC_DELAY];
  assign mac.qbits    = qbits_q;
  assign mac.x        = x_q;
  assign mac.w        = w_q;

  // one op per command all the way down the pipe
  a_ctrl_onehot: assert property (
    @(posedge clk) disable iff (!xrst)
    $onehot0({mac.accum_we, mac.clear, mac.out_en})
  ) else $error("decode: more than one control strobe active");

endmodule

//--- hw/gobou_mac.sv
`timescale 1ns/1ps

module gobou_mac
  import gobou_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  gobou_mac_if.exec                mac,
  output logic signed [DWIDTH-1:0] y
);

  logic signed [DWIDTH-1:0] x_q;
  logic signed [DWIDTH-1:0] w_q;
  logic signed [PWIDTH-1:0] pro_q;
  logic signed [DWIDTH-1:0] pro_short_q;
  logic signed [DWIDTH-1:0] accum_q;

  // qbits follows its command to the rounding stage
  logic [LWIDTH-1:0] qbits_d1;
  logic [LWIDTH-1:0] qbits_d2;

  //////////////////////////////////////////////////////////////////////
  // rounding
  //////////////////////////////////////////////////////////////////////

  // arithmetic shift, keep low half, negative products one lower
  function automatic logic signed [DWIDTH-1:0] round_pro(
    input logic signed [PWIDTH-1:0] data,
    input logic        [LWIDTH-1:0] shift
  );
    logic signed [PWIDTH-1:0] shifted;
    logic signed [DWIDTH-1:0] short;
    shifted = data >>> shift;
    short   = shifted[DWIDTH-1:0];
    if (data[PWIDTH-1]) begin
      short = short - DWIDTH'(1);
    end
    return short;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    x_q         <= mac.x;
    w_q         <= mac.w;
    pro_q       <= x_q * w_q;
    pro_short_q <= round_pro(pro_q, qbits_d2);
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      qbits_d1 <= '0;
      qbits_d2 <= '0;
    end else begin
      qbits_d1 <= mac.qbits;
      qbits_d2 <= qbits_d1;
    end
  end

  // accumulation wraps modulo 2^16
  always_ff @(posedge clk) begin
    if (!xrst) begin
      accum_q <= '0;
    end else if (mac.clear) begin
      accum_q <= '0;
    end else if (mac.accum_we) begin
      accum_q <= accum_q + pro_short_q;
    end
  end

  // snapshot for EMIT
  always_ff @(posedge clk) begin
    if (mac.out_en) begin
      y <= accum_q;
    end
  end

  a_clear_vs_we: assert property (
    @(posedge clk) disable iff (!xrst)
    !(mac.clear && mac.accum_we)
  ) else $error("mac: clear and accum_we together");

endmodule

//--- hw/gobou_result.sv
`timescale 1ns/1ps

module gobou_result
  import gobou_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  gobou_mac_if.res                 mac,
  input  logic signed [DWIDTH-1:0] y_in,
  output logic                     y_valid,
  output logic signed [DWIDTH-1:0] y
);

  // out_en and relu_en lined up with the mac y register
  logic out_d;
  logic relu_d;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_d   <= 1'b0;
      y_valid <= 1'b0;
    end else begin
      out_d   <= mac.out_en;
      y_valid <= out_d;
    end
  end

  always_ff @(posedge clk) begin
    relu_d <= mac.relu_en;
  end

  // relu clamps negatives to zero
  always_ff @(posedge clk) begin
    if (out_d) begin
      y <= (relu_d && y_in[DWIDTH-1]) ? '0 : y_in;
    end
  end

  // back-to-back outputs only from back-to-back EMITs
  a_valid_burst: assert property (
    @(posedge clk) disable iff (!xrst)
    (y_valid && $past(y_valid)) |-> ($past(mac.out_en, 2) && $past(mac.out_en, 3))
  ) else $error("result: y_valid without a matching out_en");

endmodule

//--- hw/gobou_core.sv
`timescale 1ns/1ps

module gobou_core
  import gobou_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     cmd_valid,
  input  logic [CMD_WIDTH-1:0]     cmd,
  output logic                     y_valid,
  output logic signed [DWIDTH-1:0] y
);

  //////////////////////////////////////////////////////////////////////
  // decode to execute and result
  //////////////////////////////////////////////////////////////////////

  gobou_mac_if mac_bus ();

  // accumulator snapshot from the mac
  logic signed [DWIDTH-1:0] y_mac;

  gobou_decode i_decode (
    .clk       (clk),
    .xrst      (xrst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .mac       (mac_bus.ctrl)
  );

  //////////////////////////////////////////////////////////////////////
  // multiply, round, accumulate
  //////////////////////////////////////////////////////////////////////

  gobou_mac i_mac (
    .clk  (clk),
    .xrst (xrst),
    .mac  (mac_bus.exec),
    .y    (y_mac)
  );

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  gobou_result i_result (
    .clk     (clk),
    .xrst    (xrst),
    .mac     (mac_bus.res),
    .y_in    (y_mac),
    .y_valid (y_valid),
    .y       (y)
  );

endmodule

//--- sim/gobou_core_tb.sv
`timescale 1ns/1ps

module gobou_core_tb
  import gobou_pkg::*;
();

  localparam int RAND_CMDS = 200;
  localparam int LATENCY   = 6;

  logic                     clk = 1'b0;
  logic                     xrst;
  logic                     cmd_valid;
  logic [CMD_WIDTH-1:0]     cmd;
  logic                     y_valid;
  logic signed [DWIDTH-1:0] y;

  // stimulus table
  string                    step_name[$];
  logic                     step_valid[$];
  logic [CMD_WIDTH-1:0]     step_cmd[$];
  logic signed [DWIDTH-1:0] step_exp[$];

  // outputs still owed by the DUT
  logic signed [DWIDTH-1:0] exp_val[$];
  string                    exp_name[$];
  int                       exp_cycle[$];

  int          cycle_cnt = 0;
  int          cycle_limit = 1000000;
  int          err_cnt = 0;
  logic [31:0] rng_state = 32'h4a25035b;

  gobou_core i_gobou_core (
    .clk       (clk),
    .xrst      (xrst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .y_valid   (y_valid),
    .y         (y)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////
  // command words and reference model
  ////////////////////////////////////////////////////////////////////////

  function automatic logic [CMD_WIDTH-1:0] make_cfg(input logic relu, input logic [4:0] q);
    return {CFG, {CFG_PAD{1'b0}}, relu, q};
  endfunction

  function automatic logic [CMD_WIDTH-1:0] make_mac(input logic signed [DWIDTH-1:0] x,
                                                    input logic signed [DWIDTH-1:0] w);
    return {MAC, x, w};
  endfunction

  function automatic logic [CMD_WIDTH-1:0] make_op(input gobou_op_e op);
    return {op, {(CMD_WIDTH-2){1'b0}}};
  endfunction

  // shift the full product, keep 16 bits, one lower for negative products
  function automatic logic signed [DWIDTH-1:0] expected_product(
    input logic signed [DWIDTH-1:0] x,
    input logic signed [DWIDTH-1:0] w,
    input logic        [LWIDTH-1:0] q
  );
    longint                   p;
    longint                   sh;
    logic signed [DWIDTH-1:0] s;
    p  = longint'(x) * longint'(w);
    sh = p >>> q;
    s  = sh[DWIDTH-1:0];
    if (p < 0) begin
      s = s - 16'sd1;
    end
    return s;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic add_step(input string name, input logic valid,
                          input logic [CMD_WIDTH-1:0] word,
                          input logic signed [DWIDTH-1:0] exp_y);
    step_name.push_back(name);
    step_valid.push_back(valid);
    step_cmd.push_back(word);
    step_exp.push_back(exp_y);
  endtask

  // one command per cycle, an EMIT also books its output
  task automatic drive_step(input string name, input logic valid,
                            input logic [CMD_WIDTH-1:0] word,
                            input logic signed [DWIDTH-1:0] exp_y);
    @(posedge clk);
    #1;
    cmd_valid = valid;
    cmd       = word;
    if (valid && word[CMD_WIDTH-1 -: 2] == EMIT) begin
      exp_val.push_back(exp_y);
      exp_name.push_back(name);
      exp_cycle.push_back(cycle_cnt + LATENCY);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // watchdog and output checks
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: no finish after %0d cycles", cycle_cnt);
      $display("errors: %0d", err_cnt + 1);
      $display("Testbench failed");
      $finish;
    end
  end

  always @(negedge clk) begin : check_output
    logic signed [DWIDTH-1:0] want;
    string                    name;
    int                       due;
    if (!xrst) begin
      if (y_valid === 1'b1) begin
        err_cnt++;
        $display("y_valid went high while reset was asserted");
      end
    end else if (y_valid === 1'b1) begin
      if (exp_val.size() == 0) begin
        err_cnt++;
        $display("y_valid went high with no EMIT outstanding, y = %0d", y);
      end else begin
        want = exp_val.pop_front();
        name = exp_name.pop_front();
        due  = exp_cycle.pop_front();
        if (y !== want) begin
          err_cnt++;
          $display("CHECK FAILED %s: expected y %0d, actual %0d", name, want, y);
        end
        if (cycle_cnt != due) begin
          err_cnt++;
          $display("CHECK FAILED %s latency: expected cycle %0d, actual %0d",
                   name, due, cycle_cnt);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [CMD_WIDTH-1:0]     word;
    logic signed [DWIDTH-1:0] model_acc;
    logic signed [DWIDTH-1:0] rx;
    logic signed [DWIDTH-1:0] rw;
    logic [LWIDTH-1:0]        rand_q;

    xrst      = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    rand_q    = 5'd3;
    model_acc = '0;

    add_step("reset", 1'b1, make_op(EMIT), 16'sd0);
    // 1171 - 1369 + 3
    add_step("round_q8", 1'b1, make_cfg(1'b0, 5'd8), 16'sd0);
    add_step("round_q8", 1'b1, make_op(CLEAR), 16'sd0);
    add_step("round_q8", 1'b1, make_mac(16'sd1000, 16'sd300), 16'sd0);
    add_step("round_q8", 1'b1, make_mac(-16'sd500, 16'sd700), 16'sd0);
    add_step("round_q8", 1'b1, make_mac(-16'sd20, -16'sd40), 16'sd0);
    add_step("round_q8", 1'b1, make_op(EMIT), -16'sd195);
    // same operands at qbits 4, then a fresh sum
    add_step("cfg_q4", 1'b1, make_cfg(1'b0, 5'd4), 16'sd0);
    add_step("cfg_q4", 1'b1, make_op(CLEAR), 16'sd0);
    add_step("cfg_q4", 1'b1, make_mac(16'sd1000, 16'sd300), 16'sd0);
    add_step("cfg_q4", 1'b1, make_mac(-16'sd500, 16'sd700), 16'sd0);
    add_step("cfg_q4", 1'b1, make_op(EMIT), -16'sd3126);
    add_step("cfg_q4", 1'b0, '0, 16'sd0);
    add_step("cfg_q4", 1'b1, make_op(CLEAR), 16'sd0);
    add_step("cfg_q4", 1'b1, make_mac(16'sd100, 16'sd50), 16'sd0);
    add_step("cfg_q4", 1'b1, make_op(EMIT), 16'sd312);
    add_step("relu", 1'b1, make_cfg(1'b1, 5'd0), 16'sd0);
    add_step("relu", 1'b1, make_op(CLEAR), 16'sd0);
    add_step("relu", 1'b1, make_mac(-16'sd3, 16'sd7), 16'sd0);
    add_step("relu", 1'b1, make_op(EMIT), 16'sd0);
    add_step("relu", 1'b1, make_mac(16'sd10, 16'sd5), 16'sd0);
    add_step("relu", 1'b1, make_op(EMIT), 16'sd28);
    add_step("relu", 1'b1, make_cfg(1'b0, 5'd0), 16'sd0);
    add_step("relu", 1'b1, make_op(CLEAR), 16'sd0);
    add_step("relu", 1'b1, make_mac(-16'sd3, 16'sd7), 16'sd0);
    add_step("relu", 1'b1, make_op(EMIT), -16'sd22);
    // everything back to back from here
    add_step("stream", 1'b1, make_cfg(1'b0, 5'd2), 16'sd0);
    add_step("stream", 1'b0, '0, 16'sd0);
    add_step("stream", 1'b1, make_op(CLEAR), 16'sd0);
    add_step("stream", 1'b1, make_mac(16'sd40, 16'sd10), 16'sd0);
    add_step("stream", 1'b1, make_op(EMIT), 16'sd100);
    add_step("stream", 1'b1, make_op(CLEAR), 16'sd0);
    add_step("stream", 1'b1, make_mac(16'sd7, -16'sd9), 16'sd0);
    add_step("stream", 1'b1, make_op(EMIT), -16'sd17);
    add_step("stream", 1'b1, make_op(EMIT), -16'sd17);

    cycle_limit = step_name.size() + RAND_CMDS + 50;

    repeat (4) @(posedge clk);
    #1;
    xrst = 1'b1;

    for (int i = 0; i < step_name.size(); i++) begin
      drive_step(step_name[i], step_valid[i], step_cmd[i], step_exp[i]);
    end

    // random MAC, CLEAR and EMIT at a fixed qbits
    drive_step("random", 1'b1, make_cfg(1'b0, rand_q), 16'sd0);
    drive_step("random", 1'b1, make_op(CLEAR), 16'sd0);
    for (int i = 0; i < RAND_CMDS; i++) begin
      rng_state = xorshift32(rng_state);
      case (rng_state[2:0])
        3'd0: begin
          model_acc = '0;
          word      = make_op(CLEAR);
        end
        3'd1, 3'd2: begin
          word = make_op(EMIT);
        end
        default: begin
          rng_state = xorshift32(rng_state);
          rx        = rng_state[15:0];
          rw        = rng_state[31:16];
          model_acc = model_acc + expected_product(rx, rw, rand_q);
          word      = make_mac(rx, rw);
        end
      endcase
      drive_step("random", 1'b1, word, model_acc);
    end
    drive_step("random", 1'b1, make_op(EMIT), model_acc);
    drive_step("idle", 1'b0, '0, 16'sd0);

    while (exp_val.size() != 0) begin
      @(posedge clk);
    end
    // room for a stray y_valid
    repeat (10) @(posedge clk);

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hw/gobou_pkg.sv
hw/gobou_mac_if.sv
hw/gobou_decode.sv
hw/gobou_mac.sv
hw/gobou_result.sv
hw/gobou_core.sv
sim/gobou_core_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = gobou_core_tb
FILELIST   = compile.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_MSG   = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
